//--- axil_master/axil_wr_master.sv
module axil_wr_master (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  axil_wr_cmd_if.dst               cmd,

  // AW channel
  output irq_axil_pkg::axil_addr_t awaddr_o,
  output logic                     awvalid_o,
  input  logic                     awready_i,

  // W channel
  output irq_axil_pkg::axil_data_t wdata_o,
  output irq_axil_pkg::axil_strb_t wstrb_o,
  output logic                     wvalid_o,
  input  logic                     wready_i,

  // B channel
  input  logic [1:0]               bresp_i,
  input  logic                     bvalid_i,
  output logic                     bready_o,

  output logic                     resp_err_o
);

  irq_axil_pkg::wr_state_e  state_q;
  irq_axil_pkg::wr_state_e  state_d;
  irq_axil_pkg::axil_addr_t addr_q;
  irq_axil_pkg::axil_data_t data_q;
  irq_axil_pkg::axil_strb_t strb_q;
  logic                     aw_done_q;
  logic                     w_done_q;
  logic                     resp_err_q;
  logic                     cmd_xfer;
  logic                     aw_xfer;
  logic                     w_xfer;
  logic                     b_xfer;
  logic                     aw_all;
  logic                     w_all;

  // One write in flight, so commands are only taken when idle
  assign cmd.ready = (state_q == irq_axil_pkg::WR_IDLE);
  assign cmd_xfer  = cmd.valid && cmd.ready;

  assign aw_xfer = awvalid_o && awready_i;
  assign w_xfer  = wvalid_o && wready_i;
  assign b_xfer  = bvalid_i && bready_o;

  // AW and W may finish in either order or together
  assign aw_all = aw_done_q || aw_xfer;
  assign w_all  = w_done_q || w_xfer;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      irq_axil_pkg::WR_IDLE:
      begin
        if (cmd_xfer)
        begin
          state_d = irq_axil_pkg::WR_ISSUE;
        end
      end
      irq_axil_pkg::WR_ISSUE:
      begin
        if (aw_all && w_all)
        begin
          state_d = irq_axil_pkg::WR_RESP;
        end
      end
      irq_axil_pkg::WR_RESP:
      begin
        if (b_xfer)
        begin
          state_d = irq_axil_pkg::WR_IDLE;
        end
      end
      default:
      begin
        state_d = irq_axil_pkg::WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= irq_axil_pkg::WR_IDLE;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      resp_err_q <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      aw_done_q  <= cmd_xfer ? 1'b0 : aw_all;
      w_done_q   <= cmd_xfer ? 1'b0 : w_all;
      // Response is otherwise dropped
      resp_err_q <= b_xfer && (bresp_i != 2'b00);
    end
  end

  // Payload capture on accept
  always_ff @(posedge clk_i)
  begin
    if (cmd_xfer)
    begin
      addr_q <= cmd.addr;
      data_q <= cmd.data;
      strb_q <= cmd.strb;
    end
  end

  assign awaddr_o   = addr_q;
  assign wdata_o    = data_q;
  assign wstrb_o    = strb_q;
  assign awvalid_o  = (state_q == irq_axil_pkg::WR_ISSUE) && !aw_done_q;
  assign wvalid_o   = (state_q == irq_axil_pkg::WR_ISSUE) && !w_done_q;
  assign bready_o   = (state_q == irq_axil_pkg::WR_RESP);
  assign resp_err_o = resp_err_q;

endmodule

//--- common/axil_wr_cmd_if.sv
// One doorbell write command from the arbiter to the AXI master
interface axil_wr_cmd_if;

  logic                    valid;
  logic                    ready;
  irq_axil_pkg::axil_addr_t addr;
  irq_axil_pkg::axil_data_t data;
  irq_axil_pkg::axil_strb_t strb;

  // Arbiter side, holds valid and payload until accepted
  modport src (
    output valid,
    output addr,
    output data,
    output strb,
    input  ready
  );

  // Master side
  modport dst (
    input  valid,
    input  addr,
    input  data,
    input  strb,
    output ready
  );

endinterface

//--- common/irq_axil_cfg.svh
`ifndef IRQ_AXIL_CFG_SVH
`define IRQ_AXIL_CFG_SVH

// Number of edge-triggered interrupt lines
`define IRQ_SOURCES 4

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Doorbell base, one word per source above it
`define IRQ_BASE_ADDR 32'h0000_1000

`endif

//--- common/irq_axil_pkg.sv
`include "irq_axil_cfg.svh"

package irq_axil_pkg;

  // Index width, kept at one bit for a single source
  localparam int IRQ_ID_W = (`IRQ_SOURCES > 1) ? $clog2(`IRQ_SOURCES) : 1;

  typedef logic [`IRQ_SOURCES-1:0] irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

  // Write master FSM
  typedef enum logic [1:0]
  {
    WR_IDLE,
    WR_ISSUE,
    WR_RESP
  } wr_state_e;

endpackage

//--- filelist.f
+incdir+common
common/irq_axil_pkg.sv
common/axil_wr_cmd_if.sv
rtl/irq_capture.sv
rtl/irq_arbiter.sv
axil_master/axil_wr_master.sv
rtl/irq_to_axil.sv
verification/irq_to_axil_asserts.sv
verification/irq_to_axil_checker.sv
verification/irq_to_axil_tb.sv

//--- rtl/irq_arbiter.sv
`include "irq_axil_cfg.svh"

module irq_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  irq_axil_pkg::irq_vec_t pending_i,
  output irq_axil_pkg::irq_vec_t clear_o,
  axil_wr_cmd_if.src             cmd
);

  logic                   valid_q;
  logic                   xfer;
  logic                   sel_v;
  logic                   load;
  irq_axil_pkg::irq_id_t  id_q;
  irq_axil_pkg::irq_id_t  sel_id;
  irq_axil_pkg::irq_vec_t id_onehot;
  irq_axil_pkg::irq_vec_t offer_mask;
  irq_axil_pkg::irq_vec_t avail;

  assign xfer      = valid_q && cmd.ready;
  assign id_onehot = irq_axil_pkg::irq_vec_t'(1) << id_q;

  // The source on offer is still pending, keep it out of the search
  assign offer_mask = valid_q ? id_onehot : '0;
  assign avail      = pending_i & ~offer_mask;

  // Lowest index wins
  always_comb
  begin
    sel_v  = 1'b0;
    sel_id = '0;
    for (int i = `IRQ_SOURCES - 1; i >= 0; i--)
    begin
      if (avail[i])
      begin
        sel_v  = 1'b1;
        sel_id = irq_axil_pkg::irq_id_t'(i);
      end
    end
  end

  // New command when the slot is empty or being emptied
  assign load = sel_v && (!valid_q || xfer);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (load)
    begin
      valid_q <= 1'b1;
    end
    else if (xfer)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      id_q <= sel_id;
    end
  end

  assign cmd.valid = valid_q;
  assign cmd.addr  = irq_axil_pkg::axil_addr_t'(`IRQ_BASE_ADDR)
                   + (irq_axil_pkg::axil_addr_t'(id_q) << 2);
  assign cmd.data  = irq_axil_pkg::axil_data_t'(id_q);
  assign cmd.strb  = '1;

  // Winner's flag drops on the transfer edge
  assign clear_o = xfer ? id_onehot : '0;

endmodule

//--- rtl/irq_capture.sv
module irq_capture (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  irq_axil_pkg::irq_vec_t irq_i,
  input  irq_axil_pkg::irq_vec_t clear_i,
  output irq_axil_pkg::irq_vec_t pending_o
);

  irq_axil_pkg::irq_vec_t irq_q;
  irq_axil_pkg::irq_vec_t irq_prev_q;
  irq_axil_pkg::irq_vec_t rise;
  irq_axil_pkg::irq_vec_t pending_q;

  // Line sample and the one before it
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      irq_q      <= '0;
      irq_prev_q <= '0;
    end
    else
    begin
      irq_q      <= irq_i;
      irq_prev_q <= irq_q;
    end
  end

  assign rise = irq_q & ~irq_prev_q;

  // Set beats clear so an edge arriving during the transfer survives
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pending_q <= '0;
    end
    else
    begin
      pending_q <= (pending_q & ~clear_i) | rise;
    end
  end

  assign pending_o = pending_q;

endmodule

//--- rtl/irq_to_axil.sv
module irq_to_axil (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  irq_axil_pkg::irq_vec_t   irq_i,

  // AW channel
  output irq_axil_pkg::axil_addr_t m_axil_awaddr_o,
  output logic [2:0]               m_axil_awprot_o,
  output logic                     m_axil_awvalid_o,
  input  logic                     m_axil_awready_i,

  // W channel
  output irq_axil_pkg::axil_data_t m_axil_wdata_o,
  output irq_axil_pkg::axil_strb_t m_axil_wstrb_o,
  output logic                     m_axil_wvalid_o,
  input  logic                     m_axil_wready_i,

  // B channel
  input  logic [1:0]               m_axil_bresp_i,
  input  logic                     m_axil_bvalid_i,
  output logic                     m_axil_bready_o,

  output logic                     resp_err_o
);

  irq_axil_pkg::irq_vec_t pending;
  irq_axil_pkg::irq_vec_t clear;

  axil_wr_cmd_if cmd_if ();

  // Edge detect and pending flags
  irq_capture u_capture (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .irq_i     (irq_i),
    .clear_i   (clear),
    .pending_o (pending)
  );

  // Lowest pending source becomes the next doorbell command
  irq_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .pending_i (pending),
    .clear_o   (clear),
    .cmd       (cmd_if.src)
  );

  axil_wr_master u_master (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd        (cmd_if.dst),
    .awaddr_o   (m_axil_awaddr_o),
    .awvalid_o  (m_axil_awvalid_o),
    .awready_i  (m_axil_awready_i),
    .wdata_o    (m_axil_wdata_o),
    .wstrb_o    (m_axil_wstrb_o),
    .wvalid_o   (m_axil_wvalid_o),
    .wready_i   (m_axil_wready_i),
    .bresp_i    (m_axil_bresp_i),
    .bvalid_i   (m_axil_bvalid_i),
    .bready_o   (m_axil_bready_o),
    .resp_err_o (resp_err_o)
  );

  // Unprivileged, secure data access
  assign m_axil_awprot_o = 3'b000;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench, pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module irq_to_axil_tb -f filelist.f &&
./obj_dir/Virq_to_axil_tb | tee /dev/stderr | grep -q "TESTS PASSED" ||
exit 1

//--- verification/irq_to_axil_asserts.sv
// AXI write handshake rules, bound into the write master
module irq_to_axil_asserts (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input irq_axil_pkg::wr_state_e state_i,
  input logic                    awvalid_i,
  input logic                    awready_i,
  input logic                    wvalid_i,
  input logic                    wready_i,
  input logic                    bvalid_i,
  input logic                    bready_i
);

  logic aw_open_q;

  // Open from an AW transfer until its B transfer
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      aw_open_q <= 1'b0;
    end
    else if (bvalid_i && bready_i)
    begin
      aw_open_q <= 1'b0;
    end
    else if (awvalid_i && awready_i)
    begin
      aw_open_q <= 1'b1;
    end
  end

  // Valid holds until its transfer
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before its transfer");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before its transfer");

  // No second AW before the previous B
  aw_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_open_q |-> !awvalid_i)
    else $error("second AW issued before the previous B");

  // Ready only in WR_IDLE, so never idle with a write still open
  busy_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_open_q |-> state_i != irq_axil_pkg::WR_IDLE)
    else $error("master back in WR_IDLE while a write is still open");

endmodule

bind axil_wr_master irq_to_axil_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .state_i   (state_q),
  .awvalid_i (awvalid_o),
  .awready_i (awready_i),
  .wvalid_i  (wvalid_o),
  .wready_i  (wready_i),
  .bvalid_i  (bvalid_i),
  .bready_i  (bready_o)
);

//--- verification/irq_to_axil_checker.sv
`include "irq_axil_cfg.svh"

module irq_to_axil_checker (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`IRQ_SOURCES-1:0]  irq_i,
  input  logic [`AXIL_ADDR_W-1:0]  awaddr_i,
  input  logic [2:0]               awprot_i,
  input  logic                     awvalid_i,
  input  logic                     awready_i,
  input  logic [`AXIL_DATA_W-1:0]  wdata_i,
  input  logic [`AXIL_DATA_W/8-1:0] wstrb_i,
  input  logic                     wvalid_i,
  input  logic                     wready_i,
  input  logic [1:0]               bresp_i,
  input  logic                     bvalid_i,
  input  logic                     bready_i,
  input  logic                     resp_err_i,
  input  logic                     ordered_i,
  output int                       errors_o,
  output int                       writes_o,
  output int                       missing_o,
  output int                       bad_b_o,
  output int                       err_pulses_o
);

  int                       outstanding [`IRQ_SOURCES];
  int                       aw_q [$];
  logic [`AXIL_DATA_W+`AXIL_DATA_W/8-1:0] w_q [$];
  logic [`IRQ_SOURCES-1:0]  irq_prev;
  logic                     rst_prev;
  logic                     err_exp;
  int                       pulses;
  int                       last_idx;

  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("FAILED %s expected %h got %h", name, exp, act);
    errors_o++;
  endtask

  always_comb
  begin
    missing_o = 0;
    for (int i = 0; i < `IRQ_SOURCES; i++)
    begin
      missing_o += outstanding[i];
    end
  end

  initial
  begin
    errors_o = 0;
    writes_o = 0;
    bad_b_o = 0;
    err_pulses_o = 0;
    pulses = 0;
    last_idx = -1;
    for (int i = 0; i < `IRQ_SOURCES; i++)
    begin
      outstanding[i] = 0;
    end
  end

  always @(posedge clk_i)
  begin
    logic [`AXIL_ADDR_W-1:0] offs;
    logic [`AXIL_DATA_W+`AXIL_DATA_W/8-1:0] wbeat;
    int idx;
    rst_prev <= rst_n_i;
    if (!rst_n_i)
    begin
      irq_prev <= '0;
      err_exp  <= 1'b0;
    end
    else
    begin
      // First cycle out of reset
      if (!rst_prev && (awvalid_i || wvalid_i || bready_i || resp_err_i))
      begin
        $display("Bus outputs not idle right after reset");
        errors_o++;
      end
      if (awvalid_i && pulses == 0)
      begin
        $display("Write issued before any source was pulsed");
        errors_o++;
      end
      for (int i = 0; i < `IRQ_SOURCES; i++)
      begin
        if (irq_i[i] && !irq_prev[i])
        begin
          outstanding[i]++;
          pulses++;
        end
      end
      irq_prev <= irq_i;

      if (awvalid_i && awready_i)
      begin
        offs = awaddr_i - `IRQ_BASE_ADDR;
        idx  = int'(offs >> 2);
        writes_o++;
        // Unprivileged, secure data access
        if (awprot_i != 3'b000)
        begin
          value_mismatch("m_axil_awprot_o", 32'h0, 32'(awprot_i));
        end
        if (offs[1:0] != 2'b00 || offs >= 4 * `IRQ_SOURCES)
        begin
          value_mismatch("m_axil_awaddr_o", `IRQ_BASE_ADDR, awaddr_i);
          idx = 0;
        end
        else if (outstanding[idx] == 0)
        begin
          $display("Extra write for source %0d with no pulse", idx);
          errors_o++;
        end
        else
        begin
          outstanding[idx]--;
        end
        if (ordered_i)
        begin
          if (idx <= last_idx)
          begin
            $display("Burst write for source %0d out of ascending order", idx);
            errors_o++;
          end
          last_idx = idx;
        end
        aw_q.push_back(idx);
      end
      if (!ordered_i)
      begin
        last_idx = -1;
      end

      if (wvalid_i && wready_i)
      begin
        w_q.push_back({wdata_i, wstrb_i});
      end
      // Pair W beats with their AW in order
      while (aw_q.size() > 0 && w_q.size() > 0)
      begin
        idx   = aw_q.pop_front();
        wbeat = w_q.pop_front();
        if (wbeat[`AXIL_DATA_W+`AXIL_DATA_W/8-1:`AXIL_DATA_W/8] != idx)
        begin
          value_mismatch("m_axil_wdata_o", idx,
                         wbeat[`AXIL_DATA_W+`AXIL_DATA_W/8-1:`AXIL_DATA_W/8]);
        end
        if (wbeat[`AXIL_DATA_W/8-1:0] != '1)
        begin
          value_mismatch("m_axil_wstrb_o", 32'hf, 32'(wbeat[`AXIL_DATA_W/8-1:0]));
        end
      end

      // Error pulse one cycle after a bad B
      if (resp_err_i != err_exp)
      begin
        value_mismatch("resp_err_o", 32'(err_exp), 32'(resp_err_i));
      end
      if (resp_err_i)
      begin
        err_pulses_o++;
      end
      err_exp <= bvalid_i && bready_i && (bresp_i != 2'b00);
      if (bvalid_i && bready_i && bresp_i != 2'b00)
      begin
        bad_b_o++;
      end
    end
  end

endmodule

//--- verification/irq_to_axil_tb.sv
`include "irq_axil_cfg.svh"

module irq_to_axil_tb;

  localparam int NUM_EVENTS = 64;
  localparam int MAX_CYCLES = 200 * NUM_EVENTS + 1000;

  logic                      clk;
  logic                      rst_n;
  logic [`IRQ_SOURCES-1:0]   irq;
  logic [`AXIL_ADDR_W-1:0]   awaddr;
  logic [2:0]                awprot;
  logic                      awvalid;
  logic                      awready;
  logic [`AXIL_DATA_W-1:0]   wdata;
  logic [`AXIL_DATA_W/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic                      resp_err;
  logic                      ordered;
  logic                      b_hold;
  logic                      aw_got;
  logic                      w_got;
  logic [`IRQ_SOURCES-1:0]   busy;
  integer                    stim_seed;
  integer                    slave_seed;
  int                        events;
  int                        cycles;
  int                        errors;
  int                        writes;
  int                        missing;
  int                        bad_b;
  int                        err_pulses;

  irq_to_axil uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .irq_i            (irq),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awprot_o  (awprot),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (awready),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (wready),
    .m_axil_bresp_i   (bresp),
    .m_axil_bvalid_i  (bvalid),
    .m_axil_bready_o  (bready),
    .resp_err_o       (resp_err)
  );

  irq_to_axil_checker u_checker (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .irq_i        (irq),
    .awaddr_i     (awaddr),
    .awprot_i     (awprot),
    .awvalid_i    (awvalid),
    .awready_i    (awready),
    .wdata_i      (wdata),
    .wstrb_i      (wstrb),
    .wvalid_i     (wvalid),
    .wready_i     (wready),
    .bresp_i      (bresp),
    .bvalid_i     (bvalid),
    .bready_i     (bready),
    .resp_err_i   (resp_err),
    .ordered_i    (ordered),
    .errors_o     (errors),
    .writes_o     (writes),
    .missing_o    (missing),
    .bad_b_o      (bad_b),
    .err_pulses_o (err_pulses)
  );

  always #2 clk = ~clk;

  // Flag model, clear again once the source's AW is seen
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy <= '0;
    end
    else if (awvalid && awready)
    begin
      busy <= (busy & ~(`IRQ_SOURCES'(1) << ((awaddr - `IRQ_BASE_ADDR) >> 2))) | irq;
    end
    else
    begin
      busy <= busy | irq;
    end
  end

  // Slave with random stalls, B only once both AW and W are in
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= 2'b00;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
    end
    else
    begin
      awready <= ($random(slave_seed) & 3) != 0;
      wready  <= ($random(slave_seed) & 3) != 0;
      if (awvalid && awready)
      begin
        aw_got <= 1'b1;
      end
      if (wvalid && wready)
      begin
        w_got <= 1'b1;
      end
      if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
      else if (!bvalid && aw_got && w_got && !b_hold && ($random(slave_seed) & 1))
      begin
        bvalid <= 1'b1;
        bresp  <= (($random(slave_seed) & 7) == 0) ? 2'b10 : 2'b00;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles with writes still pending", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic drain();
    while (busy != '0 || irq != '0 || awvalid || wvalid || bready)
    begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  initial
  begin
    int idx;
    clk = 1'b0;
    rst_n = 1'b0;
    irq = '0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = 2'b00;
    ordered = 1'b0;
    b_hold = 1'b0;
    cycles = 0;
    events = 0;
    stim_seed = 32'h46e60e1a;
    slave_seed = 32'h46e60e1a;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (10) @(posedge clk);

    // All sources at once while B is stalled
    b_hold <= 1'b1;
    ordered <= 1'b1;
    @(posedge clk);
    irq <= '1;
    events += `IRQ_SOURCES;
    @(posedge clk);
    irq <= '0;
    repeat (20) @(posedge clk);
    b_hold <= 1'b0;
    drain();
    ordered <= 1'b0;

    while (events < NUM_EVENTS)
    begin
      @(posedge clk);
      idx = $unsigned($random(stim_seed)) % `IRQ_SOURCES;
      if (!busy[idx] && !irq[idx] && ($random(stim_seed) & 3) == 0)
      begin
        irq <= `IRQ_SOURCES'(1) << idx;
        events++;
      end
      else
      begin
        irq <= '0;
      end
    end
    @(posedge clk);
    irq <= '0;
    drain();

    if (missing != 0)
    begin
      $display("%0d writes missing at end of test", missing);
    end
    $display("Writes %0d, bad responses %0d, error pulses %0d, missing %0d, errors %0d",
             writes, bad_b, err_pulses, missing, errors);
    if (errors == 0 && missing == 0 && bad_b == err_pulses && writes == events)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
